// ==== Bender.yml ====
package:
  name: adc_display

sources:
  - adc_display_pkg.sv
  - i2c_bit_timer.sv
  - i2c_adc_reader.sv
  - adc_bcd_formatter.sv
  - seg_scanner.sv
  - adc_display_top.sv
  - target: test
    files:
      - adc_display_checker.sv
      - tb_adc_display.sv

// ==== adc_bcd_formatter.sv ====
/*
 * turns each adc sample into an eight-digit frame: label on the left,
 * the reading right-aligned with leading zeros blanked, dashes on an ack error
 */
`timescale 1ns/1ps

module adc_bcd_formatter import adc_display_pkg::*; (
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	input  adc_sample_t    sample,
	input  logic           sample_valid,
	output display_frame_t frame
);

	localparam display_frame_t RESET_FRAME = '{DIG_LABEL_A, DIG_BLANK, DIG_BLANK,
		DIG_BLANK, DIG_BLANK, DIG_BLANK, DIG_BLANK, DIG_BLANK};

	logic [3:0]     hundreds;
	logic [3:0]     tens;
	logic [3:0]     units;
	display_frame_t frame_next;

	always_comb begin
		hundreds = 4'(sample.value / 8'd100);
		tens     = 4'((sample.value / 8'd10) % 8'd10);
		units    = 4'(sample.value % 8'd10);
	end

	always_comb begin
		frame_next = RESET_FRAME;
		if (sample.ack_error) begin
			frame_next[2] = DIG_DASH;
			frame_next[1] = DIG_DASH;
			frame_next[0] = DIG_DASH;
		end else begin
			// zero reading still shows a single 0
			frame_next[0] = digit_code_e'(units);
			if (hundreds != 4'd0) begin
				frame_next[2] = digit_code_e'(hundreds);
				frame_next[1] = digit_code_e'(tens);
			end else if (tens != 4'd0) begin
				frame_next[1] = digit_code_e'(tens);
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			frame <= RESET_FRAME;
		else if (sample_valid)
			frame <= frame_next;
	end

endmodule

// ==== adc_display.f ====
adc_display_pkg.sv
i2c_bit_timer.sv
i2c_adc_reader.sv
adc_bcd_formatter.sv
seg_scanner.sv
adc_display_top.sv
adc_display_checker.sv
tb_adc_display.sv

// ==== adc_display_checker.sv ====
/*
 * display checker for the adc display testbench. predicts the frame from the
 * stimulus table at each stop condition and compares every scanned digit
 */
`timescale 1ns/1ps

module adc_display_checker #(
	parameter int NUM_ROWS = 10
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  logic                     scl,
	input  logic                     sda,
	input  logic [7:0]               seg_number,
	input  logic [7:0]               seg_choice,
	input  logic [NUM_ROWS-1:0][8:0] stim_rows,
	output int                       error_count,
	output int                       check_count,
	output int                       rows_checked
);

	// two full scans before a new frame is trusted
	localparam int SETTLE_STEPS = 16;

	logic [8:0] row;
	logic       have_row;
	int         stop_count;
	int         settle;
	int         row_checks;
	logic       prev_scl;
	logic       prev_sda;
	logic [7:0] prev_choice;

	// reverse of the active-low segment patterns, 14 for anything unknown
	function automatic logic [3:0] segments_to_code(input logic [7:0] seg);
		case (seg)
			8'hc0: return 4'd0;
			8'hf9: return 4'd1;
			8'ha4: return 4'd2;
			8'hb0: return 4'd3;
			8'h99: return 4'd4;
			8'h92: return 4'd5;
			8'h82: return 4'd6;
			8'hf8: return 4'd7;
			8'h80: return 4'd8;
			8'h90: return 4'd9;
			8'hff: return 4'd10;
			8'hbf: return 4'd11;
			8'h88: return 4'd15;
			default: return 4'd14;
		endcase
	endfunction

	// label, blanks, then the reading right-aligned without leading zeros
	function automatic logic [3:0] expected_code(input int pos, input logic [8:0] r,
		input logic valid);
		int v;
		v = r[7:0];
		if (pos == 7)
			return 4'd15;
		if (pos >= 3 || !valid)
			return 4'd10;
		if (r[8])
			return 4'd11;
		case (pos)
			0: return 4'(v % 10);
			1: return (v >= 10) ? 4'((v / 10) % 10) : 4'd10;
			default: return (v >= 100) ? 4'(v / 100) : 4'd10;
		endcase
	endfunction

	function automatic logic [7:0] digit_char(input logic [3:0] code);
		if (code <= 4'd9)
			return "0" + code;
		case (code)
			4'd10: return "_";
			4'd11: return "-";
			4'd15: return "A";
			default: return "?";
		endcase
	endfunction

	function automatic int low_bits(input logic [7:0] v);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			if (v[i] === 1'b0)
				n++;
		return n;
	endfunction

	initial begin
		error_count  = 0;
		check_count  = 0;
		rows_checked = 0;
	end

	always @(negedge sys_clk) begin : watch
		int         pos;
		logic [3:0] want;
		logic [3:0] got;
		if (!sys_rst_n) begin
			have_row    = 1'b0;
			stop_count  = 0;
			settle      = SETTLE_STEPS;
			row_checks  = 0;
			prev_scl    = 1'b1;
			prev_sda    = 1'b1;
			prev_choice = 8'h7f;
		end else begin
			// a stop means the next table row is on its way to the display
			if (prev_scl && scl && !prev_sda && sda) begin
				if (stop_count < NUM_ROWS)
					row = stim_rows[stop_count];
				have_row   = 1'b1;
				stop_count++;
				settle     = SETTLE_STEPS;
				row_checks = 0;
			end
			if (low_bits(seg_choice) != 1) begin
				$display("error %0t: seg_choice %b does not select exactly one digit",
					$time, seg_choice);
				error_count++;
			end else if (seg_choice != prev_choice) begin
				if (settle > 0) begin
					settle--;
				end else begin
					pos = 0;
					for (int i = 0; i < 8; i++)
						if (!seg_choice[i])
							pos = i;
					want = expected_code(pos, row, have_row);
					got  = segments_to_code(seg_number);
					check_count++;
					if (got !== want) begin
						$display("error %0t: digit %0d expected %s, got %s (segments %h)",
							$time, pos, digit_char(want), digit_char(got), seg_number);
						error_count++;
					end
					row_checks++;
					if (have_row && row_checks == 8)
						rows_checked++;
				end
			end
			prev_scl    = scl;
			prev_sda    = sda;
			prev_choice = seg_choice;
		end
	end

endmodule

// ==== adc_display_pkg.sv ====
/*
 * shared types for the adc display design: digit codes, the sample
 * passed from the i2c reader and the eight-digit frame that feeds the scanner
 */
package adc_display_pkg;

	// what one display position shows
	typedef enum logic [3:0] {
		DIG_0       = 4'd0,
		DIG_1       = 4'd1,
		DIG_2       = 4'd2,
		DIG_3       = 4'd3,
		DIG_4       = 4'd4,
		DIG_5       = 4'd5,
		DIG_6       = 4'd6,
		DIG_7       = 4'd7,
		DIG_8       = 4'd8,
		DIG_9       = 4'd9,
		DIG_BLANK   = 4'd10,
		DIG_DASH    = 4'd11,
		DIG_LABEL_A = 4'd15
	} digit_code_e;

	typedef struct packed {
		logic [7:0] value;
		logic       ack_error;
	} adc_sample_t;

	// index 7 is the leftmost digit
	typedef digit_code_e [7:0] display_frame_t;

	// active-low segments, bit 7 is the decimal point and stays dark
	function automatic logic [7:0] SEG_PATTERN(input digit_code_e code);
		case (code)
			DIG_0:       return 8'hc0;
			DIG_1:       return 8'hf9;
			DIG_2:       return 8'ha4;
			DIG_3:       return 8'hb0;
			DIG_4:       return 8'h99;
			DIG_5:       return 8'h92;
			DIG_6:       return 8'h82;
			DIG_7:       return 8'hf8;
			DIG_8:       return 8'h80;
			DIG_9:       return 8'h90;
			DIG_DASH:    return 8'hbf;
			DIG_LABEL_A: return 8'h88;
			default:     return 8'hff;
		endcase
	endfunction

endpackage

// ==== adc_display_top.sv ====
/*
 * top level of the adc display: the i2c reader paced by its bit timer,
 * the decimal formatter and the seven-segment scanner
 */
`timescale 1ns/1ps

module adc_display_top import adc_display_pkg::*; #(
	parameter int         CLK_FREQ_HZ  = 50_000_000,
	parameter int         SCL_FREQ_HZ  = 100_000,
	parameter int         SCAN_FREQ_HZ = 8_000,
	parameter logic [6:0] DEVICE_ADDR  = 7'b101_0100,
	parameter logic [7:0] REG_ADDR     = 8'h00
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       scl,
	inout  wire        sda,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	logic           run;
	logic           phase_tick;
	logic [1:0]     phase;
	adc_sample_t    sample;
	logic           sample_valid;
	display_frame_t frame;

	i2c_bit_timer #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.SCL_FREQ_HZ (SCL_FREQ_HZ)
	) i2c_bit_timer_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.run        (run),
		.phase_tick (phase_tick),
		.phase      (phase)
	);

	i2c_adc_reader #(
		.DEVICE_ADDR (DEVICE_ADDR),
		.REG_ADDR    (REG_ADDR)
	) i2c_adc_reader_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.phase_tick   (phase_tick),
		.phase        (phase),
		.run          (run),
		.sample       (sample),
		.sample_valid (sample_valid),
		.scl          (scl),
		.sda          (sda)
	);

	adc_bcd_formatter adc_bcd_formatter_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.frame        (frame)
	);

	seg_scanner #(
		.CLK_FREQ_HZ  (CLK_FREQ_HZ),
		.SCAN_FREQ_HZ (SCAN_FREQ_HZ)
	) seg_scanner_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frame      (frame),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

// ==== i2c_adc_reader.sv ====
/*
 * i2c master that reads one register of the adc over and over.
 * each pass writes the register pointer, reads one byte after a repeated
 * start and reports the result as a one-cycle sample strobe
 */
`timescale 1ns/1ps

module i2c_adc_reader import adc_display_pkg::*; #(
	parameter logic [6:0] DEVICE_ADDR = 7'h54,
	parameter logic [7:0] REG_ADDR    = 8'h00
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        phase_tick,
	input  logic [1:0]  phase,
	output logic        run,
	output adc_sample_t sample,
	output logic        sample_valid,
	output logic        scl,
	inout  wire         sda
);

	typedef enum logic [3:0] {
		IDLE,
		START,
		SEND_BYTE,
		GET_ACK,
		RESTART,
		READ_BYTE,
		SEND_NACK,
		STOP,
		GAP
	} state_t;

	state_t     state;
	logic       scl_low;
	logic       sda_oe;
	logic [1:0] sda_sync;
	logic       sda_in;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic [1:0] byte_idx;
	logic       nack_seen;

	// only this master drives scl, so released means high
	assign scl = !scl_low;
	assign sda = sda_oe ? 1'b0 : 1'bz;
	assign run = (state != IDLE);

	// pin read back through two flops
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			sda_sync <= 2'b11;
		else
			sda_sync <= {sda_sync[0], sda};
	end
	assign sda_in = sda_sync[1];

	// quarters: 0 set sda, 1 raise scl, 2 sample, 3 drop scl
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= IDLE;
			scl_low      <= 1'b0;
			sda_oe       <= 1'b0;
			bit_cnt      <= 3'd0;
			byte_idx     <= 2'd0;
			nack_seen    <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			if (state == IDLE) begin
				nack_seen <= 1'b0;
				state     <= START;
			end else if (phase_tick) begin
				case (state)
					// sda falls while scl is high
					START, RESTART: begin
						case (phase)
							2'd0: sda_oe <= 1'b0;
							2'd1: scl_low <= 1'b0;
							2'd2: sda_oe <= 1'b1;
							default: begin
								scl_low <= 1'b1;
								bit_cnt <= 3'd0;
								if (state == START)
									byte_idx <= 2'd0;
								state <= SEND_BYTE;
							end
						endcase
					end
					SEND_BYTE: begin
						case (phase)
							2'd0: sda_oe <= !shift[7];
							2'd1: scl_low <= 1'b0;
							2'd2: ;
							default: begin
								scl_low <= 1'b1;
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7)
									state <= GET_ACK;
							end
						endcase
					end
					GET_ACK: begin
						case (phase)
							2'd0: sda_oe <= 1'b0;
							2'd1: scl_low <= 1'b0;
							2'd2: if (sda_in) nack_seen <= 1'b1;
							default: begin
								scl_low  <= 1'b1;
								bit_cnt  <= 3'd0;
								byte_idx <= byte_idx + 2'd1;
								if (nack_seen)
									state <= STOP;
								else if (byte_idx == 2'd0)
									state <= SEND_BYTE;
								else if (byte_idx == 2'd1)
									state <= RESTART;
								else
									state <= READ_BYTE;
							end
						endcase
					end
					READ_BYTE: begin
						case (phase)
							2'd0: sda_oe <= 1'b0;
							2'd1: scl_low <= 1'b0;
							2'd2: ;
							default: begin
								scl_low <= 1'b1;
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7)
									state <= SEND_NACK;
							end
						endcase
					end
					// sda left high, the last byte is not acknowledged
					SEND_NACK: begin
						case (phase)
							2'd0: sda_oe <= 1'b0;
							2'd1: scl_low <= 1'b0;
							2'd2: ;
							default: begin
								scl_low <= 1'b1;
								state   <= STOP;
							end
						endcase
					end
					// sda rises while scl is high, scl stays released
					STOP: begin
						case (phase)
							2'd0: sda_oe <= 1'b1;
							2'd1: scl_low <= 1'b0;
							2'd2: sda_oe <= 1'b0;
							default: begin
								sample_valid <= 1'b1;
								state        <= GAP;
							end
						endcase
					end
					// one idle scl period before the next pass
					GAP: begin
						if (phase == 2'd3)
							state <= IDLE;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// shift register for both directions, plus the reported sample
	always_ff @(posedge sys_clk) begin
		if (phase_tick) begin
			case (state)
				START: if (phase == 2'd3) shift <= {DEVICE_ADDR, 1'b0};
				RESTART: if (phase == 2'd3) shift <= {DEVICE_ADDR, 1'b1};
				SEND_BYTE: if (phase == 2'd3) shift <= {shift[6:0], 1'b0};
				GET_ACK: if (phase == 2'd3 && byte_idx == 2'd0) shift <= REG_ADDR;
				READ_BYTE: if (phase == 2'd2) shift <= {shift[6:0], sda_in};
				STOP: begin
					if (phase == 2'd3) begin
						sample.value     <= nack_seen ? 8'd0 : shift;
						sample.ack_error <= nack_seen;
					end
				end
				default: ;
			endcase
		end
	end

	a_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_valid |=> !sample_valid);

	a_idle_scl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == IDLE) |-> scl);

endmodule

// ==== i2c_bit_timer.sv ====
/*
 * quarter-period tick generator for the i2c master. while run is high it
 * pulses phase_tick four times per scl period and reports the quarter index
 */
`timescale 1ns/1ps

module i2c_bit_timer #(
	parameter int CLK_FREQ_HZ = 50_000_000,
	parameter int SCL_FREQ_HZ = 100_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       run,
	output logic       phase_tick,
	output logic [1:0] phase
);

	localparam int QUARTER = CLK_FREQ_HZ / (4 * SCL_FREQ_HZ);
	localparam int CNT_W   = (QUARTER > 1) ? $clog2(QUARTER) : 1;

	logic [CNT_W-1:0] cnt;

	// first tick comes right away when run rises
	assign phase_tick = run && (cnt == '0);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt   <= '0;
			phase <= 2'd0;
		end else if (!run) begin
			cnt   <= '0;
			phase <= 2'd0;
		end else if (phase_tick) begin
			cnt   <= CNT_W'(QUARTER - 1);
			phase <= phase + 2'd1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// needs a quarter of at least two clocks
	a_tick_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		phase_tick |=> !phase_tick);

endmodule

// ==== seg_scanner.sv ====
/*
 * multiplexed driver for the eight-digit common-anode display.
 * steps from the leftmost digit to the rightmost and wraps, one digit per
 * refresh interval, with segments and digit select registered together
 */
`timescale 1ns/1ps

module seg_scanner import adc_display_pkg::*; #(
	parameter int CLK_FREQ_HZ  = 50_000_000,
	parameter int SCAN_FREQ_HZ = 8_000
) (
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	input  display_frame_t frame,
	output logic [7:0]     seg_number,
	output logic [7:0]     seg_choice
);

	localparam int STEP  = CLK_FREQ_HZ / SCAN_FREQ_HZ;
	localparam int CNT_W = (STEP > 1) ? $clog2(STEP) : 1;

	logic [CNT_W-1:0] refresh_cnt;
	logic             step;
	logic [2:0]       pos;
	logic [2:0]       pos_next;

	assign step     = (refresh_cnt == '0);
	// 0 wraps back to 7
	assign pos_next = pos - 3'd1;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			refresh_cnt <= CNT_W'(STEP - 1);
			pos         <= 3'd7;
			seg_choice  <= 8'h7f;
			seg_number  <= SEG_PATTERN(DIG_LABEL_A);
		end else if (step) begin
			refresh_cnt <= CNT_W'(STEP - 1);
			pos         <= pos_next;
			seg_choice  <= ~(8'b1 << pos_next);
			seg_number  <= SEG_PATTERN(frame[pos_next]);
		end else begin
			refresh_cnt <= refresh_cnt - 1'b1;
		end
	end

	// exactly one digit enabled at any time
	a_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice));

endmodule

// ==== tb_adc_display.sv ====
/*
 * testbench for the adc display. an i2c slave model answers the reader
 * from a stimulus table, the checker compares the scanned display, and a
 * watchdog bounds the run
 */
`timescale 1ns/1ps

module tb_adc_display;

	localparam int         CLK_FREQ_HZ  = 100_000_000;
	localparam int         SCL_FREQ_HZ  = 2_500_000;
	localparam int         SCAN_FREQ_HZ = 12_500_000;
	localparam logic [6:0] DEVICE_ADDR  = 7'h4a;
	localparam logic [7:0] REG_ADDR     = 8'h01;
	localparam int         NUM_ROWS     = 10;
	localparam int         SCL_CYCLES   = CLK_FREQ_HZ / SCL_FREQ_HZ;
	localparam int         SCAN_CYCLES  = 8 * (CLK_FREQ_HZ / SCAN_FREQ_HZ);
	// start, four bytes with their ack bits, restart, stop and the gap period
	localparam int         TXN_CYCLES   = 40 * SCL_CYCLES + 2;
	localparam int         WATCHDOG_CYCLES = NUM_ROWS * (TXN_CYCLES + 2 * SCAN_CYCLES) * 2;

	typedef enum int {SL_IDLE, SL_RECV, SL_ACK, SL_SEND, SL_MACK, SL_STOP} slave_phase_e;

	logic                     sys_clk;
	logic                     sys_rst_n;
	wire                      scl;
	wire                      sda;
	logic [7:0]               seg_number;
	logic [7:0]               seg_choice;
	logic                     sda_low;
	logic                     drive_next;
	// one row per reading with the address nack flag in bit 8 above the value
	logic [NUM_ROWS-1:0][8:0] stim_rows;
	int                       row_idx;
	int                       bus_errors;
	int                       display_errors;
	int                       display_checks;
	int                       rows_checked;
	integer                   seed;
	event                     txn_done;

	// slave model state
	slave_phase_e             sl_phase;
	int                       sl_byte;
	int                       sl_bits;
	logic [7:0]               sl_shift;
	logic                     sl_nacked;
	logic                     txn_open;
	logic                     prev_scl;
	logic                     prev_sda;

	pullup (sda);
	assign sda = sda_low ? 1'b0 : 1'bz;

	always #5 sys_clk = ~sys_clk;

	adc_display_top #(
		.CLK_FREQ_HZ  (CLK_FREQ_HZ),
		.SCL_FREQ_HZ  (SCL_FREQ_HZ),
		.SCAN_FREQ_HZ (SCAN_FREQ_HZ),
		.DEVICE_ADDR  (DEVICE_ADDR),
		.REG_ADDR     (REG_ADDR)
	) adc_display_top_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda        (sda),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	adc_display_checker #(
		.NUM_ROWS (NUM_ROWS)
	) adc_display_checker_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.scl          (scl),
		.sda          (sda),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.stim_rows    (stim_rows),
		.error_count  (display_errors),
		.check_count  (display_checks),
		.rows_checked (rows_checked)
	);

	task automatic open_transfer();
		if (!txn_open) begin
			txn_open  = 1'b1;
			sl_byte   = 0;
			sl_nacked = 1'b0;
		end else if (sl_byte != 2) begin
			$display("error %0t: repeated start after byte %0d", $time, sl_byte);
			bus_errors++;
		end
		sl_phase   = SL_RECV;
		sl_bits    = 0;
		drive_next = 1'b0;
	endtask

	task automatic close_transfer();
		if (sl_phase != SL_STOP) begin
			$display("error %0t: stop condition before the transfer was complete", $time);
			bus_errors++;
		end
		txn_open   = 1'b0;
		sl_phase   = SL_IDLE;
		drive_next = 1'b0;
		-> txn_done;
	endtask

	task automatic sample_bit();
		case (sl_phase)
			SL_RECV: begin
				sl_shift = {sl_shift[6:0], sda};
				sl_bits++;
			end
			SL_SEND: sl_bits++;
			SL_MACK: begin
				if (!sda) begin
					$display("error %0t: master acknowledged the data byte", $time);
					bus_errors++;
				end
				sl_phase = SL_STOP;
			end
			default: ;
		endcase
	endtask

	task automatic advance_bit();
		logic [7:0] expected;
		case (sl_phase)
			SL_RECV: begin
				if (sl_bits == 8) begin
					case (sl_byte)
						0: expected = {DEVICE_ADDR, 1'b0};
						1: expected = REG_ADDR;
						default: expected = {DEVICE_ADDR, 1'b1};
					endcase
					if (sl_shift !== expected) begin
						$display("error %0t: byte %0d on the bus is %h, expected %h",
							$time, sl_byte, sl_shift, expected);
						bus_errors++;
					end
					sl_nacked  = (sl_byte == 0) && stim_rows[row_idx][8];
					drive_next = !sl_nacked;
					sl_phase   = SL_ACK;
				end
			end
			SL_ACK: begin
				sl_byte++;
				sl_bits = 0;
				if (sl_nacked) begin
					drive_next = 1'b0;
					sl_phase   = SL_STOP;
				end else if (sl_byte == 3) begin
					sl_shift   = stim_rows[row_idx][7:0];
					drive_next = !sl_shift[7];
					sl_phase   = SL_SEND;
				end else begin
					drive_next = 1'b0;
					sl_phase   = SL_RECV;
				end
			end
			SL_SEND: begin
				if (sl_bits == 8) begin
					drive_next = 1'b0;
					sl_phase   = SL_MACK;
				end else begin
					drive_next = !sl_shift[7 - sl_bits];
				end
			end
			default: ;
		endcase
	endtask

	// sda changes a little after the rising edge
	always @(posedge sys_clk)
		sda_low <= #1 drive_next;

	// bus events are taken mid-cycle where scl and sda are settled
	always @(negedge sys_clk) begin
		if (!sys_rst_n) begin
			sl_phase = SL_IDLE;
			txn_open = 1'b0;
			prev_scl = 1'b1;
			prev_sda = 1'b1;
		end else begin
			if (prev_scl && scl && prev_sda && !sda)
				open_transfer();
			else if (prev_scl && scl && !prev_sda && sda)
				close_transfer();
			else if (!prev_scl && scl)
				sample_bit();
			else if (prev_scl && !scl)
				advance_bit();
			prev_scl = scl;
			prev_sda = sda;
		end
	end

	initial begin
		sys_rst_n  = 1'b0;
		sys_clk    = 1'b0;
		sda_low    = 1'b0;
		drive_next = 1'b0;
		row_idx    = 0;
		bus_errors = 0;
		seed       = 32'h9904_8b7b;
		stim_rows[0] = {1'b0, 8'd0};
		stim_rows[1] = {1'b0, 8'd7};
		stim_rows[2] = {1'b0, 8'd42};
		stim_rows[3] = {1'b0, 8'd99};
		stim_rows[4] = {1'b0, 8'd100};
		stim_rows[5] = {1'b0, 8'd255};
		stim_rows[6] = {1'b1, 8'd0};
		stim_rows[7] = {1'b0, 8'd128};
		stim_rows[8] = {1'b0, 8'($random(seed))};
		stim_rows[9] = {1'b0, 8'($random(seed))};
		repeat (8) @(posedge sys_clk);
		#1 sys_rst_n = 1'b1;
		// one reader transaction per row
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_idx = r;
			@(txn_done);
		end
		repeat (4 * SCAN_CYCLES) @(posedge sys_clk);
		if (rows_checked != NUM_ROWS)
			$display("only %0d of %0d readings were seen on the display",
				rows_checked, NUM_ROWS);
		$display("errors: bus %0d, display %0d (display checks %0d)",
			bus_errors, display_errors, display_checks);
		if (bus_errors == 0 && display_errors == 0 && rows_checked == NUM_ROWS)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// bounded by the table length
	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
